// File: sources.f
rtl/trav_pkg.sv
rtl/stall_buf.sv
rtl/sync_fifo.sv
rtl/leaf_route.sv
rtl/trav_math.sv
rtl/trav_decide.sv
rtl/trav_unit.sv
tb/trav_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator and run; pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module trav_unit_tb -o sim_trav \
  && ./obj_dir/sim_trav | grep -q "SIMULATION PASSED" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// File: tb/trav_unit_tb.sv
// ====================
// trav_unit_tb
// random tree cache and ray store traffic with
// random consumer stalls, scoreboards on all ports
// ====================
`timescale 1ns/1ps

module trav_unit_tb
  import trav_pkg::*;
();

  localparam int N_RANDOM = 598;  // plus two directed nodes
  localparam int TMO      = 2000;

  logic clk = 1'b0;
  logic rst_n;
  logic tcache_valid, tcache_low_empty, tcache_high_empty, tcache_stall;
  ray_id_t tcache_ray_id;
  node_id_t tcache_node_id, tcache_right_id;
  node_type_e tcache_node_type;
  tval_t tcache_split, tcache_t_min, tcache_t_max;
  ln_tri_t tcache_ln_tri;
  logic rs_req_valid, rs_req_low_empty, rs_req_high_empty, rs_req_stall;
  ray_id_t rs_req_ray_id;
  node_id_t rs_req_node_id, rs_req_right_id;
  tval_t rs_req_split, rs_req_t_min, rs_req_t_max;
  logic rs_rsp_valid, rs_rsp_low_empty, rs_rsp_high_empty, rs_rsp_stall;
  ray_id_t rs_rsp_ray_id;
  node_id_t rs_rsp_node_id, rs_rsp_right_id;
  tval_t rs_rsp_split, rs_rsp_t_min, rs_rsp_t_max, rs_rsp_origin, rs_rsp_inv_dir;
  logic tarb_valid, tarb_stall, ss_valid, ss_push, ss_pop, ss_stall;
  ray_id_t tarb_ray_id, ss_ray_id, larb_ray_id, list_ray_id;
  node_id_t tarb_node_id, ss_node_id;
  tval_t tarb_t_min, tarb_t_max, ss_t_min, ss_t_max, list_t_max;
  logic larb_valid, larb_stall, list_valid, list_stall;
  ln_tri_t larb_ln_tri;

  logic [137:0] rs_exp_q[$];
  logic [137:0] req_q[$];      // requests waiting for a ray store answer
  logic [31:0]  larb_exp_q[$];
  logic [39:0]  list_exp_q[$];
  logic [87:0]  tarb_exp_q[$];
  logic [89:0]  ss_exp_q[$];
  int  words_q[$];             // tarb and ss words still owed per accepted response
  int  cyc = 0;
  int  leaf_acc_cyc, rsp_acc_cyc;
  bit  quiet = 1'b1;           // no stalls, immediate answers
  bit  lat_check = 1'b0;
  bit  rsp_done = 1'b0;
  bit  rsp_stall_seen = 1'b0;

  trav_unit i_dut (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [137:0] got,
                                 input logic [137:0] exp);
    report_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
  endtask

  function automatic tval_t rand_q(input int lo, input int span);
    return tval_t'($urandom % (span * 65536)) + tval_t'(lo * 65536);
  endfunction

  // ss fields beyond ray and flags only carry meaning for a push
  function automatic logic [89:0] ss_pack(input ray_id_t r, input logic push,
      input logic pop, input node_id_t n, input tval_t lo, input tval_t hi);
    if (!push) return {r, push, pop, 80'd0};
    return {r, push, pop, n, lo, hi};
  endfunction

  // reference decision for one ray store answer
  task automatic predict_decision(input ray_id_t r, input node_id_t n, input node_id_t rt,
      input logic le, input logic he, input tval_t split, input tval_t org,
      input tval_t inv, input tval_t tmin, input tval_t tmax);
    longint   p;
    tval_t    diff, tmid;
    node_id_t near_id, far_id;
    logic     near_e, far_e, v_near, v_far, ng, fg;
    diff = split - org;
    p = longint'(diff) * longint'(inv);
    tmid = p[47:16];
    near_id = (inv >= 0) ? node_id_t'(n + 16'd1) : rt;
    far_id  = (inv >= 0) ? rt : node_id_t'(n + 16'd1);
    near_e  = (inv >= 0) ? le : he;
    far_e   = (inv >= 0) ? he : le;
    v_near = 1'b1;
    v_far  = 1'b1;
    if (tmid >= tmax) v_far = 1'b0;
    if (tmid <= tmin) v_near = 1'b0;
    ng = v_near && !near_e;
    fg = v_far && !far_e;
    if (ng && fg) begin
      tarb_exp_q.push_back({r, near_id, tmin, tmid});
      ss_exp_q.push_back(ss_pack(r, 1'b1, 1'b0, far_id, tmid, tmax));
    end else if (ng) begin
      tarb_exp_q.push_back({r, near_id, tmin, v_far ? tmid : tmax});
    end else if (fg) begin
      tarb_exp_q.push_back({r, far_id, v_near ? tmid : tmin, tmax});
    end else begin
      ss_exp_q.push_back(ss_pack(r, 1'b0, 1'b1, '0, '0, '0));
    end
    words_q.push_back((ng && fg) ? 2 : 1);
  endtask

  // one tarb or ss word of the oldest unfinished response went out
  task automatic retire_word();
    if (words_q.size() > 0) begin
      words_q[0] = words_q[0] - 1;
      if (words_q[0] == 0) void'(words_q.pop_front());
    end
  endtask

  // starts 2 ns after an edge and returns 2 ns after the accepting edge
  task automatic send_node(input bit leaf);
    int t;
    tcache_valid = 1'b1;
    tcache_ray_id = ray_id_t'($urandom);
    tcache_node_id = node_id_t'($urandom);
    tcache_right_id = node_id_t'($urandom);
    tcache_node_type = leaf ? NODE_LEAF : node_type_e'($urandom % 3);
    tcache_low_empty = 1'($urandom % 2);
    tcache_high_empty = 1'($urandom % 2);
    tcache_split = tval_t'($urandom);
    tcache_ln_tri = ln_tri_t'($urandom);
    tcache_t_min = tval_t'($urandom);
    tcache_t_max = tval_t'($urandom);
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > TMO) report_error("timeout waiting for tcache to accept a node");
    end while (tcache_stall);
    #2;
    tcache_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (rs_exp_q.size() || req_q.size() || rs_rsp_valid || larb_exp_q.size() ||
           list_exp_q.size() || tarb_exp_q.size() || ss_exp_q.size()) begin
      @(posedge clk);
      #2;
      t++;
      if (t > 20 * TMO) report_error("timeout waiting for outputs to drain");
    end
  endtask

  always @(negedge clk) begin
    if (cyc >= 1 && cyc <= 5) begin
      assert (!(tarb_valid || ss_valid || larb_valid || list_valid || rs_req_valid ||
                tcache_stall || rs_rsp_stall))
        else report_error("valid or stall output high around reset");
    end
    // output registers hold at most one response beyond the credit count
    if (cyc >= 1) begin
      assert (!rs_rsp_stall || words_q.size() >= TRAV_FIFO_DEPTH)
        else report_error("rs response stall high while the result queue has room");
      assert (rs_rsp_stall || words_q.size() <= TRAV_FIFO_DEPTH)
        else report_error("rs response stall low with the result queue full");
    end
  end

  // expected words enter the queues at the accepting edge
  always @(posedge clk) begin
    if (rst_n && tcache_valid && !tcache_stall) begin
      if (tcache_node_type == NODE_LEAF) begin
        larb_exp_q.push_back({tcache_ray_id, tcache_ln_tri});
        list_exp_q.push_back({tcache_ray_id, tcache_t_max});
        leaf_acc_cyc = cyc;
      end else begin
        rs_exp_q.push_back({tcache_ray_id, tcache_node_id, tcache_right_id,
                            tcache_low_empty, tcache_high_empty, tcache_split,
                            tcache_t_min, tcache_t_max});
      end
    end
    if (rs_rsp_stall) rsp_stall_seen = 1'b1;
    if (rs_rsp_valid && !rs_rsp_stall) begin
      predict_decision(rs_rsp_ray_id, rs_rsp_node_id, rs_rsp_right_id, rs_rsp_low_empty,
                       rs_rsp_high_empty, rs_rsp_split, rs_rsp_origin, rs_rsp_inv_dir,
                       rs_rsp_t_min, rs_rsp_t_max);
      rsp_acc_cyc = cyc;
      rsp_done = 1'b1;
    end
  end

  always @(posedge clk) begin
    logic [137:0] got;
    if (rs_req_valid && !rs_req_stall) begin
      got = {rs_req_ray_id, rs_req_node_id, rs_req_right_id, rs_req_low_empty,
             rs_req_high_empty, rs_req_split, rs_req_t_min, rs_req_t_max};
      assert (rs_exp_q.size() > 0) else report_error("unexpected word on rs request port");
      assert (got == rs_exp_q[0]) else report_mismatch("rs_req", got, rs_exp_q[0]);
      void'(rs_exp_q.pop_front());
      req_q.push_back(got);
    end
    if (larb_valid && !larb_stall) begin
      assert (larb_exp_q.size() > 0) else report_error("unexpected word on larb port");
      assert ({larb_ray_id, larb_ln_tri} == larb_exp_q[0])
        else report_mismatch("larb", {larb_ray_id, larb_ln_tri}, larb_exp_q[0]);
      if (lat_check) begin
        assert (cyc - leaf_acc_cyc == 3) else report_error("larb latency is not 3 cycles");
      end
      void'(larb_exp_q.pop_front());
    end
    if (list_valid && !list_stall) begin
      assert (list_exp_q.size() > 0) else report_error("unexpected word on list port");
      assert ({list_ray_id, list_t_max} == list_exp_q[0])
        else report_mismatch("list", {list_ray_id, list_t_max}, list_exp_q[0]);
      if (lat_check) begin
        assert (cyc - leaf_acc_cyc == 3) else report_error("list latency is not 3 cycles");
      end
      void'(list_exp_q.pop_front());
    end
    if (tarb_valid && !tarb_stall) begin
      assert (tarb_exp_q.size() > 0) else report_error("unexpected word on tarb port");
      assert ({tarb_ray_id, tarb_node_id, tarb_t_min, tarb_t_max} == tarb_exp_q[0])
        else report_mismatch("tarb", {tarb_ray_id, tarb_node_id, tarb_t_min, tarb_t_max},
                             tarb_exp_q[0]);
      if (lat_check) begin
        assert (cyc - rsp_acc_cyc == 5) else report_error("response latency is not 5 cycles");
      end
      void'(tarb_exp_q.pop_front());
      retire_word();
    end
    if (ss_valid && !ss_stall) begin
      got = ss_pack(ss_ray_id, ss_push, ss_pop, ss_node_id, ss_t_min, ss_t_max);
      assert (ss_exp_q.size() > 0) else report_error("unexpected word on ss port");
      assert (got == ss_exp_q[0]) else report_mismatch("ss", got, ss_exp_q[0]);
      if (lat_check) begin
        assert (cyc - rsp_acc_cyc == 5) else report_error("response latency is not 5 cycles");
      end
      void'(ss_exp_q.pop_front());
      retire_word();
    end
  end

  // ray store model answering each request in order
  initial begin
    logic [137:0] rq;
    forever begin
      @(posedge clk);
      #2;
      if (rsp_done) begin
        rs_rsp_valid = 1'b0;
        rsp_done = 1'b0;
      end
      if (!rs_rsp_valid && req_q.size() > 0 && (quiet || $urandom % 4 != 0)) begin
        rq = req_q.pop_front();
        {rs_rsp_ray_id, rs_rsp_node_id, rs_rsp_right_id, rs_rsp_low_empty,
         rs_rsp_high_empty} = rq[137:96];
        rs_rsp_split = rand_q(-8, 16);
        rs_rsp_origin = rand_q(-8, 16);
        rs_rsp_inv_dir = tval_t'(16384 + $urandom % 131072);
        if ($urandom % 2) rs_rsp_inv_dir = -rs_rsp_inv_dir;
        if ($urandom % 16 == 0) rs_rsp_inv_dir = '0;
        rs_rsp_t_min = rand_q(-4, 12);
        rs_rsp_t_max = rs_rsp_t_min + rand_q(1, 8);  // t_min below t_max
        rs_rsp_valid = 1'b1;
      end
    end
  end

  // consumer stalls in phases of 30, 90 and 0 percent
  initial begin
    int pct;
    forever begin
      @(posedge clk);
      #2;
      case ((cyc / 256) % 3)
        0: pct = 30;
        1: pct = 90;
        default: pct = 0;
      endcase
      if (quiet) pct = 0;
      tarb_stall = ($urandom % 100) < pct;
      ss_stall = ($urandom % 100) < pct;
      larb_stall = ($urandom % 100) < pct;
      list_stall = ($urandom % 100) < pct;
      rs_req_stall = ($urandom % 100) < pct;
    end
  end

  initial begin
    void'($urandom(7369));
    rst_n = 1'b0;
    tcache_valid = 1'b0;
    tcache_ray_id = '0;
    tcache_node_id = '0;
    tcache_right_id = '0;
    tcache_node_type = NODE_X;
    tcache_low_empty = 1'b0;
    tcache_high_empty = 1'b0;
    tcache_split = '0;
    tcache_ln_tri = '0;
    tcache_t_min = '0;
    tcache_t_max = '0;
    {rs_req_stall, tarb_stall, ss_stall, larb_stall, list_stall} = '0;
    rs_rsp_valid = 1'b0;
    {rs_rsp_ray_id, rs_rsp_node_id, rs_rsp_right_id} = '0;
    {rs_rsp_low_empty, rs_rsp_high_empty} = '0;
    {rs_rsp_split, rs_rsp_t_min, rs_rsp_t_max, rs_rsp_origin, rs_rsp_inv_dir} = '0;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    // idle latency of one leaf and one interior node
    lat_check = 1'b1;
    send_node(1'b1);
    wait_drain();
    send_node(1'b0);
    wait_drain();
    lat_check = 1'b0;
    quiet = 1'b0;
    for (int i = 0; i < N_RANDOM; i++) begin
      send_node(($urandom % 5) < 2);
      if ($urandom % 4 == 0) begin
        @(posedge clk);
        #2;
      end
    end
    wait_drain();
    repeat (10) @(posedge clk);
    assert (rsp_stall_seen) else report_error("rs response stall never rose");
    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    #5ms;
    $display("timeout of the whole run");
    $display("SIMULATION FAILED");
    $fatal(1);
  end

endmodule

// File: rtl/trav_unit.sv
// ====================
// trav_unit
// kd-tree traversal stage top: buffers tree cache
// fetches, routes leaves to the leaf path and interior
// nodes through the ray store into the slab math
// ====================
`timescale 1ns/1ps

module trav_unit
  import trav_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  // tree cache in
  input  logic       tcache_valid,
  input  ray_id_t    tcache_ray_id,
  input  node_id_t   tcache_node_id,
  input  node_type_e tcache_node_type,
  input  node_id_t   tcache_right_id,
  input  logic       tcache_low_empty,
  input  logic       tcache_high_empty,
  input  tval_t      tcache_split,
  input  ln_tri_t    tcache_ln_tri,
  input  tval_t      tcache_t_min,
  input  tval_t      tcache_t_max,
  output logic       tcache_stall,
  // ray store request
  output logic       rs_req_valid,
  output ray_id_t    rs_req_ray_id,
  output node_id_t   rs_req_node_id,
  output node_id_t   rs_req_right_id,
  output logic       rs_req_low_empty,
  output logic       rs_req_high_empty,
  output tval_t      rs_req_split,
  output tval_t      rs_req_t_min,
  output tval_t      rs_req_t_max,
  input  logic       rs_req_stall,
  // ray store response
  input  logic       rs_rsp_valid,
  input  ray_id_t    rs_rsp_ray_id,
  input  node_id_t   rs_rsp_node_id,
  input  node_id_t   rs_rsp_right_id,
  input  logic       rs_rsp_low_empty,
  input  logic       rs_rsp_high_empty,
  input  tval_t      rs_rsp_split,
  input  tval_t      rs_rsp_t_min,
  input  tval_t      rs_rsp_t_max,
  input  tval_t      rs_rsp_origin,
  input  tval_t      rs_rsp_inv_dir,
  output logic       rs_rsp_stall,
  // tree arbiter
  output logic       tarb_valid,
  output ray_id_t    tarb_ray_id,
  output node_id_t   tarb_node_id,
  output tval_t      tarb_t_min,
  output tval_t      tarb_t_max,
  input  logic       tarb_stall,
  // ray stack
  output logic       ss_valid,
  output ray_id_t    ss_ray_id,
  output logic       ss_push,
  output logic       ss_pop,
  output node_id_t   ss_node_id,
  output tval_t      ss_t_min,
  output tval_t      ss_t_max,
  input  logic       ss_stall,
  // leaf arbiter and hit list
  output logic       larb_valid,
  output ray_id_t    larb_ray_id,
  output ln_tri_t    larb_ln_tri,
  input  logic       larb_stall,
  output logic       list_valid,
  output ray_id_t    list_ray_id,
  output tval_t      list_t_max,
  input  logic       list_stall
);

  logic [$bits(ray_id_t)+3*$bits(tval_t)+2*$bits(node_id_t)+$bits(ln_tri_t)+3:0] b_word;
  logic       b_valid;
  logic       b_stall;
  ray_id_t    b_ray_id;
  node_id_t   b_node_id;
  logic [1:0] b_type;
  node_id_t   b_right_id;
  logic       b_low_empty;
  logic       b_high_empty;
  tval_t      b_split;
  ln_tri_t    b_ln_tri;
  tval_t      b_t_min;
  tval_t      b_t_max;
  logic       b_leaf;
  logic       leaf_stall;

  logic       rsp_take;
  logic [MATH_LATENCY-1:0]           flight;
  logic [$clog2(MATH_LATENCY+1)-1:0] math_in_flight;

  logic       m_valid;
  ray_id_t    m_ray_id;
  tval_t      m_t_min;
  tval_t      m_t_max;
  tval_t      m_t_mid;
  node_id_t   m_near_id;
  node_id_t   m_far_id;
  logic       m_near_empty;
  logic       m_far_empty;
  logic       m_visit_near;
  logic       m_visit_far;

  stall_buf #(.WIDTH($bits(b_word))) u_in_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (tcache_valid),
    .in_data   ({tcache_ray_id, tcache_node_id, tcache_node_type, tcache_right_id,
                 tcache_low_empty, tcache_high_empty, tcache_split, tcache_ln_tri,
                 tcache_t_min, tcache_t_max}),
    .in_stall  (tcache_stall),
    .out_valid (b_valid),
    .out_data  (b_word),
    .out_stall (b_stall)
  );

  assign {b_ray_id, b_node_id, b_type, b_right_id, b_low_empty, b_high_empty,
          b_split, b_ln_tri, b_t_min, b_t_max} = b_word;

  // head of buffer blocks until its own path takes it, keeps order
  assign b_leaf  = (b_type == NODE_LEAF);
  assign b_stall = b_leaf ? leaf_stall : rs_req_stall;

  assign rs_req_valid      = b_valid && !b_leaf;
  assign rs_req_ray_id     = b_ray_id;
  assign rs_req_node_id    = b_node_id;
  assign rs_req_right_id   = b_right_id;
  assign rs_req_low_empty  = b_low_empty;
  assign rs_req_high_empty = b_high_empty;
  assign rs_req_split      = b_split;
  assign rs_req_t_min      = b_t_min;
  assign rs_req_t_max      = b_t_max;

  leaf_route u_leaf_route (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (b_valid && b_leaf),
    .in_ray_id   (b_ray_id),
    .in_ln_tri   (b_ln_tri),
    .in_t_max    (b_t_max),
    .in_stall    (leaf_stall),
    .larb_valid  (larb_valid),
    .larb_ray_id (larb_ray_id),
    .larb_ln_tri (larb_ln_tri),
    .larb_stall  (larb_stall),
    .list_valid  (list_valid),
    .list_ray_id (list_ray_id),
    .list_t_max  (list_t_max),
    .list_stall  (list_stall)
  );

  assign rsp_take = rs_rsp_valid && !rs_rsp_stall;

  // one bit per math stage, mirrors the pipeline valids
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flight <= '0;
    end else begin
      flight <= {flight[MATH_LATENCY-2:0], rsp_take};
    end
  end

  always_comb begin
    math_in_flight = '0;
    for (int i = 0; i < MATH_LATENCY; i++) begin
      math_in_flight = math_in_flight + flight[i];
    end
  end

  trav_math u_math (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (rsp_take),
    .in_ray_id      (rs_rsp_ray_id),
    .in_node_id     (rs_rsp_node_id),
    .in_right_id    (rs_rsp_right_id),
    .in_low_empty   (rs_rsp_low_empty),
    .in_high_empty  (rs_rsp_high_empty),
    .in_split       (rs_rsp_split),
    .in_origin      (rs_rsp_origin),
    .in_inv_dir     (rs_rsp_inv_dir),
    .in_t_min       (rs_rsp_t_min),
    .in_t_max       (rs_rsp_t_max),
    .out_valid      (m_valid),
    .out_ray_id     (m_ray_id),
    .out_t_min      (m_t_min),
    .out_t_max      (m_t_max),
    .out_t_mid      (m_t_mid),
    .out_near_id    (m_near_id),
    .out_far_id     (m_far_id),
    .out_near_empty (m_near_empty),
    .out_far_empty  (m_far_empty),
    .out_visit_near (m_visit_near),
    .out_visit_far  (m_visit_far)
  );

  trav_decide u_decide (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (m_valid),
    .in_ray_id      (m_ray_id),
    .in_t_min       (m_t_min),
    .in_t_max       (m_t_max),
    .in_t_mid       (m_t_mid),
    .in_near_id     (m_near_id),
    .in_far_id      (m_far_id),
    .in_near_empty  (m_near_empty),
    .in_far_empty   (m_far_empty),
    .in_visit_near  (m_visit_near),
    .in_visit_far   (m_visit_far),
    .math_in_flight (math_in_flight),
    .rsp_stall      (rs_rsp_stall),
    .tarb_valid     (tarb_valid),
    .tarb_ray_id    (tarb_ray_id),
    .tarb_node_id   (tarb_node_id),
    .tarb_t_min     (tarb_t_min),
    .tarb_t_max     (tarb_t_max),
    .tarb_stall     (tarb_stall),
    .ss_valid       (ss_valid),
    .ss_ray_id      (ss_ray_id),
    .ss_push        (ss_push),
    .ss_pop         (ss_pop),
    .ss_node_id     (ss_node_id),
    .ss_t_min       (ss_t_min),
    .ss_t_max       (ss_t_max),
    .ss_stall       (ss_stall)
  );

endmodule

// File: rtl/trav_decide.sv
// ====================
// trav_decide
// result queue with credit stall, issues one
// tree fetch, stack push or stack pop per node
// ====================
`timescale 1ns/1ps

module trav_decide
  import trav_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  ray_id_t  in_ray_id,
  input  tval_t    in_t_min,
  input  tval_t    in_t_max,
  input  tval_t    in_t_mid,
  input  node_id_t in_near_id,
  input  node_id_t in_far_id,
  input  logic     in_near_empty,
  input  logic     in_far_empty,
  input  logic     in_visit_near,
  input  logic     in_visit_far,
  input  logic [$clog2(MATH_LATENCY+1)-1:0] math_in_flight,
  output logic     rsp_stall,
  output logic     tarb_valid,
  output ray_id_t  tarb_ray_id,
  output node_id_t tarb_node_id,
  output tval_t    tarb_t_min,
  output tval_t    tarb_t_max,
  input  logic     tarb_stall,
  output logic     ss_valid,
  output ray_id_t  ss_ray_id,
  output logic     ss_push,
  output logic     ss_pop,
  output node_id_t ss_node_id,
  output tval_t    ss_t_min,
  output tval_t    ss_t_max,
  input  logic     ss_stall
);

  logic [$bits(ray_id_t)+3*$bits(tval_t)+2*$bits(node_id_t)+3:0] q_word;
  ray_id_t  q_ray_id;
  tval_t    q_t_min;
  tval_t    q_t_max;
  tval_t    q_t_mid;
  node_id_t q_near_id;
  node_id_t q_far_id;
  logic     q_near_empty;
  logic     q_far_empty;
  logic     q_visit_near;
  logic     q_visit_far;
  logic     q_empty;
  logic [$clog2(TRAV_FIFO_DEPTH+1)-1:0] q_count;
  logic     near_go;
  logic     far_go;
  logic     load;

  assign {q_ray_id, q_t_min, q_t_max, q_t_mid, q_near_id, q_far_id,
          q_near_empty, q_far_empty, q_visit_near, q_visit_far} = q_word;

  sync_fifo #(
    .WIDTH ($bits(q_word)),
    .DEPTH (TRAV_FIFO_DEPTH)
  ) u_result_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (in_valid),  // credit keeps room for every word in flight
    .wr_data ({in_ray_id, in_t_min, in_t_max, in_t_mid, in_near_id, in_far_id,
               in_near_empty, in_far_empty, in_visit_near, in_visit_far}),
    .rd_en   (load),
    .rd_data (q_word),
    .full    (),
    .empty   (q_empty),
    .count   (q_count)
  );

  assign rsp_stall = (q_count + math_in_flight) >= TRAV_FIFO_DEPTH;

  assign near_go = q_visit_near && !q_near_empty;
  assign far_go  = q_visit_far && !q_far_empty;
  assign load    = !q_empty && (!tarb_valid || !tarb_stall) && (!ss_valid || !ss_stall);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tarb_valid <= 1'b0;
      ss_valid   <= 1'b0;
    end else begin
      tarb_valid <= (load && (near_go || far_go)) || (tarb_valid && tarb_stall);
      ss_valid   <= (load && (near_go == far_go)) || (ss_valid && ss_stall);  // push or pop
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tarb_ray_id  <= q_ray_id;
      tarb_node_id <= near_go ? q_near_id : q_far_id;
      // clip at t_mid only where the other child is also visited
      tarb_t_min   <= (!near_go && q_visit_near) ? q_t_mid : q_t_min;
      tarb_t_max   <= (near_go && q_visit_far) ? q_t_mid : q_t_max;
      ss_ray_id    <= q_ray_id;
      ss_push      <= near_go && far_go;
      ss_pop       <= !near_go && !far_go;
      ss_node_id   <= q_far_id;
      ss_t_min     <= q_t_mid;
      ss_t_max     <= q_t_max;
    end
  end

endmodule

// File: rtl/trav_math.sv
// ====================
// trav_math
// three-stage slab math: split distance t_mid,
// near/far child pick and the visit flags
// ====================
`timescale 1ns/1ps

module trav_math
  import trav_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  ray_id_t  in_ray_id,
  input  node_id_t in_node_id,
  input  node_id_t in_right_id,
  input  logic     in_low_empty,
  input  logic     in_high_empty,
  input  tval_t    in_split,
  input  tval_t    in_origin,
  input  tval_t    in_inv_dir,
  input  tval_t    in_t_min,
  input  tval_t    in_t_max,
  output logic     out_valid,
  output ray_id_t  out_ray_id,
  output tval_t    out_t_min,
  output tval_t    out_t_max,
  output tval_t    out_t_mid,
  output node_id_t out_near_id,
  output node_id_t out_far_id,
  output logic     out_near_empty,
  output logic     out_far_empty,
  output logic     out_visit_near,
  output logic     out_visit_far
);

  logic              s1_valid;
  logic              s2_valid;
  ray_id_t           s1_ray_id;
  ray_id_t           s2_ray_id;
  tval_t             s1_t_min;
  tval_t             s1_t_max;
  tval_t             s2_t_min;
  tval_t             s2_t_max;
  tval_t             s1_diff;
  tval_t             s1_inv_dir;
  tval_t             s2_t_mid;
  node_id_t          s1_near_id;
  node_id_t          s1_far_id;
  node_id_t          s2_near_id;
  node_id_t          s2_far_id;
  logic              s1_near_empty;
  logic              s1_far_empty;
  logic              s2_near_empty;
  logic              s2_far_empty;
  logic              dir_neg;
  logic signed [63:0] prod;

  assign dir_neg = in_inv_dir < 0;   // negative direction: high child is near
  assign prod    = s1_diff * s1_inv_dir;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    // stage 1, distance to the split plane
    s1_ray_id     <= in_ray_id;
    s1_t_min      <= in_t_min;
    s1_t_max      <= in_t_max;
    s1_diff       <= in_split - in_origin;
    s1_inv_dir    <= in_inv_dir;
    s1_near_id    <= dir_neg ? in_right_id : in_node_id + 16'd1;
    s1_far_id     <= dir_neg ? in_node_id + 16'd1 : in_right_id;
    s1_near_empty <= dir_neg ? in_high_empty : in_low_empty;
    s1_far_empty  <= dir_neg ? in_low_empty : in_high_empty;
    // stage 2, scale back to Q16.16
    s2_ray_id     <= s1_ray_id;
    s2_t_min      <= s1_t_min;
    s2_t_max      <= s1_t_max;
    s2_t_mid      <= prod[47:16];
    s2_near_id    <= s1_near_id;
    s2_far_id     <= s1_far_id;
    s2_near_empty <= s1_near_empty;
    s2_far_empty  <= s1_far_empty;
    // stage 3, range compare
    out_ray_id     <= s2_ray_id;
    out_t_min      <= s2_t_min;
    out_t_max      <= s2_t_max;
    out_t_mid      <= s2_t_mid;
    out_near_id    <= s2_near_id;
    out_far_id     <= s2_far_id;
    out_near_empty <= s2_near_empty;
    out_far_empty  <= s2_far_empty;
    out_visit_near <= s2_t_mid > s2_t_min;   // plane at or before entry skips near
    out_visit_far  <= s2_t_mid < s2_t_max;   // plane at or past exit skips far
  end

endmodule

// File: rtl/leaf_route.sv
// ====================
// leaf_route
// queues leaf nodes and hands each one to the
// leaf arbiter and the hit list as a pair
// ====================
`timescale 1ns/1ps

module leaf_route
  import trav_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  ray_id_t in_ray_id,
  input  ln_tri_t in_ln_tri,
  input  tval_t   in_t_max,
  output logic    in_stall,
  output logic    larb_valid,
  output ray_id_t larb_ray_id,
  output ln_tri_t larb_ln_tri,
  input  logic    larb_stall,
  output logic    list_valid,
  output ray_id_t list_ray_id,
  output tval_t   list_t_max,
  input  logic    list_stall
);

  logic [$bits(ray_id_t)+$bits(ln_tri_t)+$bits(tval_t)-1:0] q_word;
  ray_id_t q_ray_id;
  ln_tri_t q_ln_tri;
  tval_t   q_t_max;
  logic    q_full;
  logic    q_empty;
  logic    q_load;

  assign in_stall = q_full;
  assign {q_ray_id, q_ln_tri, q_t_max} = q_word;

  sync_fifo #(
    .WIDTH ($bits(q_word)),
    .DEPTH (LEAF_FIFO_DEPTH)
  ) u_leaf_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (in_valid && !q_full),
    .wr_data ({in_ray_id, in_ln_tri, in_t_max}),
    .rd_en   (q_load),
    .rd_data (q_word),
    .full    (q_full),
    .empty   (q_empty),
    .count   ()
  );

  // refill only when both sides are free or draining this cycle
  assign q_load = !q_empty && (!larb_valid || !larb_stall) && (!list_valid || !list_stall);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      larb_valid <= 1'b0;
      list_valid <= 1'b0;
    end else begin
      larb_valid <= q_load || (larb_valid && larb_stall);
      list_valid <= q_load || (list_valid && list_stall);
    end
  end

  always_ff @(posedge clk) begin
    if (q_load) begin
      larb_ray_id <= q_ray_id;
      larb_ln_tri <= q_ln_tri;
      list_ray_id <= q_ray_id;
      list_t_max  <= q_t_max;
    end
  end

endmodule

// File: rtl/sync_fifo.sv
// ====================
// sync_fifo
// circular buffer queue with show-ahead read data,
// full, empty and an occupancy count
// ====================
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_en,
  input  logic [WIDTH-1:0]           wr_data,
  input  logic                       rd_en,
  output logic [WIDTH-1:0]           rd_data,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     do_wr;
  logic                     do_rd;

  assign full    = (count == DEPTH);
  assign empty   = (count == 0);
  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign rd_data = mem[rd_ptr];  // head word visible before the pop

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: rtl/stall_buf.sv
// ====================
// stall_buf
// two-entry skid buffer on a valid/stall port,
// registered output and registered upstream stall
// ====================
`timescale 1ns/1ps

module stall_buf #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic [WIDTH-1:0] in_data,
  output logic             in_stall,
  output logic             out_valid,
  output logic [WIDTH-1:0] out_data,
  input  logic             out_stall
);

  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             out_free;

  assign out_free = !out_valid || !out_stall;
  assign in_stall = skid_valid;  // only raised once the spare slot is taken

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid || in_valid;  // skid word drains first
      skid_valid <= 1'b0;
    end else if (in_valid && !skid_valid) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) out_data <= skid_valid ? skid_data : in_data;
    if (!out_free && !skid_valid) skid_data <= in_data;
  end

endmodule

// File: rtl/trav_pkg.sv
// ====================
// trav_pkg
// shared field types, node type encoding and
// queue depths for the kd-tree traversal stage
// ====================
package trav_pkg;

  typedef logic [7:0]         ray_id_t;
  typedef logic [15:0]        node_id_t;  // low child sits at parent + 1
  typedef logic signed [31:0] tval_t;     // Q16.16
  typedef logic [23:0]        ln_tri_t;   // leaf triangle list pointer and count

  typedef enum logic [1:0] {
    NODE_X    = 2'd0,
    NODE_Y    = 2'd1,
    NODE_Z    = 2'd2,
    NODE_LEAF = 2'd3
  } node_type_e;

  localparam int LEAF_FIFO_DEPTH = 4;
  localparam int TRAV_FIFO_DEPTH = 4;
  localparam int MATH_LATENCY    = 3;   // stages in trav_math

endpackage
